/* logic/fetch_pkg.sv */
package fetch_pkg;

	localparam int num_warps = 8;
	localparam int warp_idx_width = $clog2(num_warps);
	localparam int pc_width = 32;
	localparam int instr_width = 32;
	localparam int imem_addr_width = 10;
	localparam int imem_depth = 1 << imem_addr_width;

	typedef logic [instr_width-1:0] instr_t;
	typedef logic [pc_width-1:0] pc_t;
	typedef logic [num_warps-1:0] warp_mask_t;
	typedef logic [warp_idx_width-1:0] warp_idx_t;
	typedef logic [imem_addr_width-1:0] imem_addr_t;
	typedef logic [num_warps-1:0][pc_width-1:0] warp_pc_array_t;

	// One fetch lane as seen by decode.
	typedef struct packed {
		instr_t instr;
		pc_t pc_plus4;
		warp_mask_t valid;
	} fetch_slot_t;

	typedef struct packed {
		logic valid;
		warp_idx_t warp;
		pc_t target;
	} pc_redirect_t;

	typedef struct packed {
		logic wen;
		imem_addr_t addr;
		instr_t data;
	} imem_load_t;

	// Word index of a byte PC.
	function automatic imem_addr_t pc_index(pc_t pc);
		return pc[imem_addr_width+1:2];
	endfunction

endpackage

/* logic/warp_pc_table.sv */
`timescale 1ns/1ps

module warp_pc_table #(
	parameter int unsigned warp_pc_stride = 256
) (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::pc_redirect_t pc_redirect,
	input fetch_pkg::fetch_slot_t slot0,
	input fetch_pkg::fetch_slot_t slot1,
	output fetch_pkg::warp_pc_array_t warp_pcs
);
	import fetch_pkg::*;

	warp_pc_array_t pc_next;
	warp_mask_t redirect_hit;
	warp_mask_t advance0;
	warp_mask_t advance1;

	assign advance0 = slot0.valid;
	assign advance1 = slot1.valid;

	// Decode the redirect target warp.
	always_comb begin
		redirect_hit = '0;
		if (pc_redirect.valid)
			redirect_hit[pc_redirect.warp] = 1'b1;
	end

	always_comb begin
		for (int w = 0; w < num_warps; w++) begin
			pc_next[w] = warp_pcs[w];
			if (advance0[w])
				pc_next[w] = slot0.pc_plus4;
			if (advance1[w])
				pc_next[w] = slot1.pc_plus4;
			if (redirect_hit[w])
				pc_next[w] = pc_redirect.target; // Redirect beats advance.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < num_warps; w++)
				warp_pcs[w] <= pc_t'(w * warp_pc_stride); // Per-warp code region.
		end else begin
			warp_pcs <= pc_next;
		end
	end

endmodule

/* logic/warp_scheduler.sv */
`timescale 1ns/1ps

module warp_scheduler (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::warp_mask_t warp_active,
	output fetch_pkg::warp_mask_t grant0,
	output fetch_pkg::warp_mask_t grant1
);
	import fetch_pkg::*;

	warp_idx_t rr_ptr;
	warp_mask_t in_flight1; // Granted last cycle.
	warp_mask_t in_flight2; // Granted two cycles ago.
	warp_mask_t eligible;
	warp_idx_t cand;
	warp_idx_t idx0;
	warp_idx_t idx1;
	logic found0;
	logic found1;

	assign eligible = warp_active & ~in_flight1 & ~in_flight2;

	// Scan from the pointer and take the first two eligible warps.
	always_comb begin
		found0 = 1'b0;
		found1 = 1'b0;
		idx0 = rr_ptr;
		idx1 = rr_ptr;
		cand = rr_ptr;
		for (int k = 0; k < num_warps; k++) begin
			cand = rr_ptr + warp_idx_t'(k); // Wraps around.
			if (eligible[cand]) begin
				if (!found0) begin
					found0 = 1'b1;
					idx0 = cand;
				end else if (!found1) begin
					found1 = 1'b1;
					idx1 = cand;
				end
			end
		end
	end

	always_comb begin
		grant0 = '0;
		grant1 = '0;
		if (found0)
			grant0[idx0] = 1'b1;
		if (found1)
			grant1[idx1] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_ptr <= '0;
			in_flight1 <= '0;
			in_flight2 <= '0;
		end else begin
			in_flight1 <= grant0 | grant1;
			in_flight2 <= in_flight1;
			if (found1)
				rr_ptr <= idx1 + warp_idx_t'(1);
			else if (found0)
				rr_ptr <= idx0 + warp_idx_t'(1);
		end
	end

endmodule

/* logic/imem_bank.sv */
`timescale 1ns/1ps

module imem_bank (
	input logic clk,
	input fetch_pkg::imem_load_t load,
	input logic [fetch_pkg::imem_addr_width-1:0] raddr,
	output fetch_pkg::instr_t rdata
);
	import fetch_pkg::*;

	instr_t mem [imem_depth];
	imem_addr_t raddr_q;

	always_ff @(posedge clk) begin
		if (load.wen)
			mem[load.addr] <= load.data;
	end

	// Registered address then registered data.
	always_ff @(posedge clk) begin
		raddr_q <= raddr;
		rdata <= mem[raddr_q];
	end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::warp_pc_array_t warp_pcs,
	input fetch_pkg::warp_mask_t grant0,
	input fetch_pkg::warp_mask_t grant1,
	input fetch_pkg::warp_mask_t flush_simt1,
	input fetch_pkg::warp_mask_t flush_simt2,
	input fetch_pkg::warp_mask_t flush_id0,
	input fetch_pkg::warp_mask_t flush_id1,
	input fetch_pkg::warp_mask_t warp_active,
	input fetch_pkg::imem_load_t imem_load,
	output fetch_pkg::fetch_slot_t slot0,
	output fetch_pkg::fetch_slot_t slot1,
	output fetch_pkg::instr_t imem_rdata
);
	import fetch_pkg::*;

	localparam int num_lanes = 2;

	warp_mask_t flush_any;
	warp_mask_t keep;
	warp_mask_t lane_grant [num_lanes];
	pc_t pc_sel [num_lanes];
	pc_t lane_pc_plus4 [num_lanes];
	warp_mask_t lane_valid [num_lanes];
	imem_addr_t raddr0;
	imem_addr_t raddr1;
	instr_t rdata0;
	instr_t rdata1;

	// One-hot PC select, warp 0 when the grant is not one-hot.
	function automatic pc_t select_pc(warp_pc_array_t pcs, warp_mask_t sel);
		pc_t pc;
		pc = pcs[0];
		for (int w = 0; w < num_warps; w++) begin
			if (sel == warp_mask_t'(1 << w))
				pc = pcs[w];
		end
		return pc;
	endfunction

	assign lane_grant[0] = grant0;
	assign lane_grant[1] = grant1;
	assign flush_any = flush_simt1 | flush_simt2 | flush_id0 | flush_id1;
	assign keep = ~flush_any & warp_active;

	for (genvar l = 0; l < num_lanes; l++) begin : lane_g
		pc_t pc_plus4_q1;
		pc_t pc_plus4_q2;
		warp_mask_t valid_q1;
		warp_mask_t valid_q2;

		assign pc_sel[l] = select_pc(warp_pcs, lane_grant[l]);

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				pc_plus4_q1 <= '0;
				pc_plus4_q2 <= '0;
				valid_q1 <= '0;
				valid_q2 <= '0;
			end else begin
				pc_plus4_q1 <= pc_sel[l] + pc_t'(4);
				pc_plus4_q2 <= pc_plus4_q1;
				valid_q1 <= lane_grant[l] & keep; // Squash at grant.
				valid_q2 <= valid_q1 & keep; // Squash while in flight.
			end
		end

		assign lane_pc_plus4[l] = pc_plus4_q2;
		assign lane_valid[l] = valid_q2;
	end

	// Loader steals bank 0's read port.
	assign raddr0 = imem_load.wen ? imem_load.addr : pc_index(pc_sel[0]);
	assign raddr1 = pc_index(pc_sel[1]);

	imem_bank bank0_i (
		.clk(clk),
		.load(imem_load),
		.raddr(raddr0),
		.rdata(rdata0)
	);

	imem_bank bank1_i (
		.clk(clk),
		.load(imem_load),
		.raddr(raddr1),
		.rdata(rdata1)
	);

	assign slot0 = '{instr: rdata0, pc_plus4: lane_pc_plus4[0], valid: lane_valid[0]};
	assign slot1 = '{instr: rdata1, pc_plus4: lane_pc_plus4[1], valid: lane_valid[1]};
	assign imem_rdata = rdata0;

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
	parameter int unsigned warp_pc_stride = 256
) (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::imem_load_t imem_load,
	input fetch_pkg::pc_redirect_t pc_redirect,
	input fetch_pkg::warp_mask_t flush_simt1,
	input fetch_pkg::warp_mask_t flush_simt2,
	input fetch_pkg::warp_mask_t flush_id0,
	input fetch_pkg::warp_mask_t flush_id1,
	input fetch_pkg::warp_mask_t warp_active,
	output fetch_pkg::fetch_slot_t slot0,
	output fetch_pkg::fetch_slot_t slot1,
	output fetch_pkg::instr_t imem_rdata
);
	import fetch_pkg::*;

	warp_pc_array_t warp_pcs;
	warp_mask_t grant0;
	warp_mask_t grant1;

	warp_pc_table #(
		.warp_pc_stride(warp_pc_stride)
	) pc_table_i (
		.clk(clk),
		.rst_n(rst_n),
		.pc_redirect(pc_redirect),
		.slot0(slot0),
		.slot1(slot1),
		.warp_pcs(warp_pcs)
	);

	warp_scheduler scheduler_i (
		.clk(clk),
		.rst_n(rst_n),
		.warp_active(warp_active),
		.grant0(grant0),
		.grant1(grant1)
	);

	fetch_stage fetch_i (
		.clk(clk),
		.rst_n(rst_n),
		.warp_pcs(warp_pcs),
		.grant0(grant0),
		.grant1(grant1),
		.flush_simt1(flush_simt1),
		.flush_simt2(flush_simt2),
		.flush_id0(flush_id0),
		.flush_id1(flush_id1),
		.warp_active(warp_active),
		.imem_load(imem_load),
		.slot0(slot0),
		.slot1(slot1),
		.imem_rdata(imem_rdata)
	);

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int unsigned stride = 256; // Default PC stride of the top.

	logic clk;
	logic rst_n;
	imem_load_t imem_load;
	pc_redirect_t pc_redirect;
	warp_mask_t flush_simt1;
	warp_mask_t flush_simt2;
	warp_mask_t flush_id0;
	warp_mask_t flush_id1;
	warp_mask_t warp_active;
	fetch_slot_t slot0;
	fetch_slot_t slot1;
	instr_t imem_rdata;

	instr_t model_mem [imem_depth];
	pc_t next_pc [num_warps]; // PC each warp fetches next.
	int seed;
	int errors;

	fetch_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_cond(input logic cond, input string msg);
		assert (cond) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timed out at %0t while waiting for %s", $time, what);
	endtask

	function automatic int warp_of(warp_mask_t mask);
		int w;
		w = 0;
		for (int i = 0; i < num_warps; i++) begin
			if (mask[i])
				w = i;
		end
		return w;
	endfunction

	function automatic instr_t model_word(pc_t pc);
		return model_mem[pc[imem_addr_width+1:2]]; // Word index of a byte PC.
	endfunction

	task automatic check_slot(input fetch_slot_t slot, input int lane);
		int w;
		if (slot.valid != '0) begin
			w = warp_of(slot.valid);
			check_cond($onehot(slot.valid),
				$sformatf("lane %0d mask %b is not one-hot", lane, slot.valid));
			check_cond(slot.pc_plus4 == next_pc[w] + pc_t'(4),
				$sformatf("lane %0d warp %0d pc_plus4 %h, expected %h",
					lane, w, slot.pc_plus4, next_pc[w] + pc_t'(4)));
			check_cond(slot.instr == model_word(slot.pc_plus4 - pc_t'(4)),
				$sformatf("lane %0d warp %0d instr %h, expected %h",
					lane, w, slot.instr, model_word(slot.pc_plus4 - pc_t'(4))));
			next_pc[w] = next_pc[w] + pc_t'(4);
		end
	endtask

	// One clock, then both lanes are checked.
	task automatic next_cycle();
		@(posedge clk);
		#2;
		check_slot(slot0, 0);
		check_slot(slot1, 1);
		if (slot0.valid != '0)
			check_cond(slot0.valid != slot1.valid, "both lanes carry the same warp");
	endtask

	task automatic wait_for_warp(input int w, output fetch_slot_t slot, output logic found);
		int wait_cycles;
		found = 1'b0;
		slot = '0;
		wait_cycles = 0;
		while (!found && wait_cycles < 30) begin
			next_cycle();
			wait_cycles++;
			if (slot0.valid[w]) begin
				found = 1'b1;
				slot = slot0;
			end else if (slot1.valid[w]) begin
				found = 1'b1;
				slot = slot1;
			end
		end
		if (!found)
			report_timeout($sformatf("a fetch of warp %0d", w));
	endtask

	task automatic reset_and_load();
		for (int i = 0; i < 5; i++) begin
			next_cycle();
			check_cond(slot0.valid == '0 && slot1.valid == '0 &&
				slot0.pc_plus4 == '0 && slot1.pc_plus4 == '0,
				"slots not cleared during reset");
		end
		rst_n = 1'b1;
		for (int i = 0; i < 2; i++) begin
			next_cycle();
			check_cond(slot0.valid == '0 && slot1.valid == '0, "valid set after reset");
		end
		// Each word shows on imem_rdata two cycles after its address.
		for (int i = 0; i < imem_depth + 2; i++) begin
			if (i >= 2)
				check_cond(imem_rdata == model_mem[i-2],
					$sformatf("word %0d read %h, expected %h", i - 2, imem_rdata,
						model_mem[i-2]));
			if (i < imem_depth)
				imem_load = '{wen: 1'b1, addr: imem_addr_t'(i), data: model_mem[i]};
			else
				imem_load = '0;
			next_cycle();
		end
	endtask

	task automatic single_warp_stream();
		pc_t expect_pc4;
		int seen;
		int wait_cycles;
		warp_active = 8'h08;
		expect_pc4 = pc_t'(3 * stride + 4);
		seen = 0;
		wait_cycles = 0;
		while (seen < 8 && wait_cycles < 100) begin
			next_cycle();
			wait_cycles++;
			if (slot0.valid != '0 || slot1.valid != '0) begin
				check_cond(slot0.valid == 8'h08 && slot1.valid == '0,
					"slot shows a warp other than warp 3");
				check_cond(slot0.pc_plus4 == expect_pc4,
					$sformatf("warp 3 pc_plus4 %h, expected %h", slot0.pc_plus4, expect_pc4));
				expect_pc4 = expect_pc4 + pc_t'(4);
				seen++;
			end
		end
		if (seen < 8)
			report_timeout("warp 3 fetches");
	endtask

	task automatic dual_issue();
		int dual;
		int wait_cycles;
		warp_active = '1;
		dual = 0;
		wait_cycles = 0;
		while (dual < 24 && wait_cycles < 200) begin
			next_cycle();
			wait_cycles++;
			if (slot0.valid != '0 && slot1.valid != '0)
				dual++;
		end
		if (dual < 24)
			report_timeout("dual-issue cycles");
	endtask

	task automatic flush_warp5();
		pc_t resume_pc4;
		fetch_slot_t slot;
		logic found;
		resume_pc4 = next_pc[5] + pc_t'(4);
		for (int i = 0; i < 10; i++) begin
			flush_simt1 = (i % 4 == 0) ? 8'h20 : '0; // Rotate over all four sources.
			flush_simt2 = (i % 4 == 1) ? 8'h20 : '0;
			flush_id0 = (i % 4 == 2) ? 8'h20 : '0;
			flush_id1 = (i % 4 == 3) ? 8'h20 : '0;
			next_cycle();
			check_cond(!slot0.valid[5] && !slot1.valid[5], "warp 5 valid while flushed");
		end
		flush_simt1 = '0;
		flush_simt2 = '0;
		flush_id1 = '0;
		flush_id0 = '0;
		next_cycle();
		check_cond(!slot0.valid[5] && !slot1.valid[5], "warp 5 valid after flush");
		wait_for_warp(5, slot, found);
		if (found)
			check_cond(slot.pc_plus4 == resume_pc4,
				$sformatf("warp 5 resumed at %h, expected %h", slot.pc_plus4, resume_pc4));
	endtask

	task automatic redirect_warp2();
		pc_t target;
		fetch_slot_t slot;
		logic found;
		target = 32'h0000_0a40;
		pc_redirect = '{valid: 1'b1, warp: warp_idx_t'(2), target: target};
		flush_id0 = 8'h04;
		next_pc[2] = target;
		next_cycle();
		pc_redirect = '0;
		flush_id0 = '0;
		wait_for_warp(2, slot, found);
		if (found) begin
			check_cond(slot.pc_plus4 == target + pc_t'(4),
				$sformatf("warp 2 pc_plus4 %h after redirect", slot.pc_plus4));
			check_cond(slot.instr == model_word(target),
				$sformatf("warp 2 instr %h at redirect target", slot.instr));
		end
	endtask

	task automatic deactivate();
		int wait_cycles;
		warp_active = '0;
		next_cycle();
		wait_cycles = 1;
		while ((slot0.valid != '0 || slot1.valid != '0) && wait_cycles < 3) begin
			next_cycle();
			wait_cycles++;
		end
		check_cond(slot0.valid == '0 && slot1.valid == '0, "valid not cleared in 3 cycles");
		for (int i = 0; i < 12; i++) begin
			next_cycle();
			check_cond(slot0.valid == '0 && slot1.valid == '0, "valid set while inactive");
		end
	endtask

	initial begin
		seed = 42;
		errors = 0;
		rst_n = 1'b0;
		imem_load = '0;
		pc_redirect = '0;
		flush_simt1 = '0;
		flush_simt2 = '0;
		flush_id0 = '0;
		flush_id1 = '0;
		warp_active = '0;
		for (int w = 0; w < num_warps; w++)
			next_pc[w] = pc_t'(w * stride);
		for (int i = 0; i < imem_depth; i++)
			model_mem[i] = $random(seed);
		reset_and_load();
		single_warp_stream();
		dual_issue();
		flush_warp5();
		redirect_warp2();
		deactivate();
		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* filelist.f */
logic/fetch_pkg.sv
logic/warp_pc_table.sv
logic/warp_scheduler.sv
logic/imem_bank.sv
logic/fetch_stage.sv
logic/fetch_top.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetch_tb -f filelist.f \
	-Mdir obj_dir -o fetch_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
